/* src/rtf65004_defines.svh */
// data width, register count, queue depth, micro-op codes and status flag positions
`ifndef RTF65004_DEFINES_SVH
`define RTF65004_DEFINES_SVH

// width of a register, an operand and a result
`define RTF65004_WID 64
// register 0 always reads as zero and is never written
`define RTF65004_NREGS 8
// default number of entries in the issue queue
`define RTF65004_QDEPTH 4

// byte and word arithmetic
`define RTF65004_UO_LDIB 6'h00
`define RTF65004_UO_ADDW 6'h01
`define RTF65004_UO_ADDB 6'h02
`define RTF65004_UO_ADCB 6'h03
`define RTF65004_UO_SBCB 6'h04
`define RTF65004_UO_CMPB 6'h05
// byte logic and the register move
`define RTF65004_UO_ANDB 6'h06
`define RTF65004_UO_ANDC 6'h07
`define RTF65004_UO_BITB 6'h08
`define RTF65004_UO_ORB  6'h09
`define RTF65004_UO_EORB 6'h0a
`define RTF65004_UO_MOV  6'h0b
// byte shifts and rotates through the carry
`define RTF65004_UO_ASLB 6'h0c
`define RTF65004_UO_LSRB 6'h0d
`define RTF65004_UO_ROLB 6'h0e
`define RTF65004_UO_RORB 6'h0f
// full width operations
`define RTF65004_UO_ADD  6'h10
`define RTF65004_UO_SUB  6'h11
`define RTF65004_UO_CMP  6'h12
`define RTF65004_UO_AND  6'h13
`define RTF65004_UO_OR   6'h14
`define RTF65004_UO_EOR  6'h15
`define RTF65004_UO_ASL  6'h16
`define RTF65004_UO_LSR  6'h17
// flag set and clear, these only touch the status register
`define RTF65004_UO_CLC  6'h18
`define RTF65004_UO_SEC  6'h19
`define RTF65004_UO_CLV  6'h1a
`define RTF65004_UO_SEI  6'h1b
`define RTF65004_UO_CLI  6'h1c
`define RTF65004_UO_SED  6'h1d
`define RTF65004_UO_CLD  6'h1e
`define RTF65004_UO_SEB  6'h1f
`define RTF65004_UO_CLB  6'h20
`define RTF65004_UO_XCE  6'h21

// bit positions inside the native status byte
`define RTF65004_FLAG_C 0
`define RTF65004_FLAG_Z 1
`define RTF65004_FLAG_I 2
`define RTF65004_FLAG_D 3
`define RTF65004_FLAG_B 4
`define RTF65004_FLAG_V 6
`define RTF65004_FLAG_N 7

`endif

/* src/rtf65004_pkg.sv */
// shared types for operands, status, register indices, op codes and the writeback state
`include "rtf65004_defines.svh"

package rtf65004_pkg;

	// an operand read from the register file or a result from the ALU
	typedef logic [`RTF65004_WID-1:0] word_t;

	// status register
	// the native byte sits in the low half and the alternate byte in the high half
	typedef logic [15:0] status_t;

	// index into the register file, wide enough for every register
	typedef logic [$clog2(`RTF65004_NREGS)-1:0] reg_idx_t;

	// micro-op code as carried from decode
	typedef logic [5:0] uop_code_t;

	// state of the writeback holding register in the ALU stage
	// idle means no result is waiting, full means wb_valid_o is raised
	typedef enum logic
	{
		wb_idle,
		wb_full
	} wb_state_t;

endpackage

/* src/rtf65004_uop_if.sv */
// valid/ready channel for one issued micro-op with its operands, with source and sink modports
interface rtf65004_uop_if;

	// handshake, a transfer happens on an edge where both are high
	logic valid;
	logic ready;

	// payload, held stable by the source while valid waits for ready
	rtf65004_pkg::uop_code_t op;
	rtf65004_pkg::reg_idx_t dst;
	rtf65004_pkg::word_t a;
	rtf65004_pkg::word_t b;
	rtf65004_pkg::word_t imm;

	// the side that offers micro-ops
	modport src
	(
		output valid, op, dst, a, b, imm,
		input ready
	);

	// the side that takes micro-ops
	modport snk
	(
		input valid, op, dst, a, b, imm,
		output ready
	);

endinterface

/* src/rtf65004_regread.sv */
// register file, pending-write scoreboard and the issue register of the register-read stage
`include "rtf65004_defines.svh"

module rtf65004_regread
(
	input  logic clk_i,
	input  logic rst_n_i,
	// incoming micro-ops
	input  logic uop_valid_i,
	output logic uop_ready_o,
	input  rtf65004_pkg::uop_code_t uop_op_i,
	input  rtf65004_pkg::reg_idx_t uop_dst_i,
	input  rtf65004_pkg::reg_idx_t uop_src_a_i,
	input  rtf65004_pkg::reg_idx_t uop_src_b_i,
	input  rtf65004_pkg::word_t uop_imm_i,
	// result write port fed by the writeback handshake
	input  logic wb_we_i,
	input  rtf65004_pkg::reg_idx_t wb_dst_i,
	input  rtf65004_pkg::word_t wb_data_i,
	// issued micro-ops towards the queue
	rtf65004_uop_if.src issue
);

	// ========================================================================
	// register file and scoreboard
	// ========================================================================

	rtf65004_pkg::word_t regs_q [`RTF65004_NREGS];
	// one bit per register, set while a result for it is still in flight
	logic [`RTF65004_NREGS-1:0] pending_q;

	logic hazard;
	logic issue_free;
	logic accept;

	// issue register contents
	logic iss_valid_q;
	rtf65004_pkg::uop_code_t iss_op_q;
	rtf65004_pkg::reg_idx_t iss_dst_q;
	rtf65004_pkg::word_t iss_a_q;
	rtf65004_pkg::word_t iss_b_q;
	rtf65004_pkg::word_t iss_imm_q;

	// there is no forwarding so a micro-op waits until every register it touches is settled
	// pending bit 0 is never set so a zero destination cannot block
	assign hazard = pending_q[uop_src_a_i] | pending_q[uop_src_b_i] | pending_q[uop_dst_i];

	// the issue register can load when it is empty or handing its micro-op over this edge
	assign issue_free = !iss_valid_q || issue.ready;
	assign uop_ready_o = issue_free && !hazard;
	assign accept = uop_valid_i && uop_ready_o;

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < `RTF65004_NREGS; i++)
				regs_q[i] <= '0;
			pending_q <= '0;
		end
		else
		begin
			// register 0 is hardwired to zero and keeps its reset value
			if (wb_we_i && wb_dst_i != '0)
			begin
				regs_q[wb_dst_i] <= wb_data_i;
				pending_q[wb_dst_i] <= 1'b0;
			end
			// the hazard check keeps this from ever hitting the register cleared above
			if (accept && uop_dst_i != '0)
				pending_q[uop_dst_i] <= 1'b1;
		end
	end

	// ========================================================================
	// issue register
	// ========================================================================

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
			iss_valid_q <= 1'b0;
		else if (accept)
			iss_valid_q <= 1'b1;
		else if (issue.ready)
			iss_valid_q <= 1'b0;
	end

	// operands are sampled at acceptance, reading register 0 gives zero from the array
	always_ff @(posedge clk_i)
	begin
		if (accept)
		begin
			iss_op_q <= uop_op_i;
			iss_dst_q <= uop_dst_i;
			iss_a_q <= regs_q[uop_src_a_i];
			iss_b_q <= regs_q[uop_src_b_i];
			iss_imm_q <= uop_imm_i;
		end
	end

	assign issue.valid = iss_valid_q;
	assign issue.op = iss_op_q;
	assign issue.dst = iss_dst_q;
	assign issue.a = iss_a_q;
	assign issue.b = iss_b_q;
	assign issue.imm = iss_imm_q;

endmodule

/* src/rtf65004_uop_fifo.sv */
// in-order circular queue of issued micro-ops, depth set by parameter
`include "rtf65004_defines.svh"

module rtf65004_uop_fifo
#(
	parameter int DEPTH = `RTF65004_QDEPTH
)
(
	input  logic clk_i,
	input  logic rst_n_i,
	rtf65004_uop_if.snk wr,
	rtf65004_uop_if.src rd
);

	localparam int PW = $clog2(DEPTH);

	// payload storage, one array per field
	rtf65004_pkg::uop_code_t mem_op [DEPTH];
	rtf65004_pkg::reg_idx_t mem_dst [DEPTH];
	rtf65004_pkg::word_t mem_a [DEPTH];
	rtf65004_pkg::word_t mem_b [DEPTH];
	rtf65004_pkg::word_t mem_imm [DEPTH];

	// pointers wrap on their own because DEPTH is a power of two
	logic [PW-1:0] wr_ptr_q;
	logic [PW-1:0] rd_ptr_q;
	logic [PW:0] count_q;
	logic push;
	logic pop;

	assign wr.ready = (count_q != DEPTH[PW:0]);
	assign rd.valid = (count_q != '0);
	assign push = wr.valid && wr.ready;
	assign pop = rd.valid && rd.ready;

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			// simultaneous push and pop leaves the count alone
			if (push && !pop)
				count_q <= count_q + 1'b1;
			else if (pop && !push)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (push)
		begin
			mem_op[wr_ptr_q] <= wr.op;
			mem_dst[wr_ptr_q] <= wr.dst;
			mem_a[wr_ptr_q] <= wr.a;
			mem_b[wr_ptr_q] <= wr.b;
			mem_imm[wr_ptr_q] <= wr.imm;
		end
	end

	// head entry, only shown once the count says it was written on an earlier edge
	assign rd.op = mem_op[rd_ptr_q];
	assign rd.dst = mem_dst[rd_ptr_q];
	assign rd.a = mem_a[rd_ptr_q];
	assign rd.b = mem_b[rd_ptr_q];
	assign rd.imm = mem_imm[rd_ptr_q];

endmodule

/* src/rtf65004_alu_stage.sv */
// ALU with flag generation, status register and writeback holding register
`include "rtf65004_defines.svh"

module rtf65004_alu_stage
(
	input  logic clk_i,
	input  logic rst_n_i,
	rtf65004_uop_if.snk exe,
	output logic wb_valid_o,
	input  logic wb_ready_i,
	output rtf65004_pkg::reg_idx_t wb_dst_o,
	output rtf65004_pkg::word_t wb_data_o,
	output rtf65004_pkg::status_t status_o
);

	rtf65004_pkg::status_t status_q;
	rtf65004_pkg::status_t status_nxt;
	rtf65004_pkg::word_t res;
	rtf65004_pkg::word_t byte_x;
	rtf65004_pkg::wb_state_t state_q;
	rtf65004_pkg::reg_idx_t wb_dst_q;
	rtf65004_pkg::word_t wb_data_q;
	// byte results keep their carry or borrow in bit 8
	logic [8:0] byte_r;
	logic [5:0] shamt;
	logic carry;
	logic borrow;
	logic take;

	// ========================================================================
	// ALU
	// ========================================================================

	assign carry = status_q[`RTF65004_FLAG_C];
	assign borrow = ~status_q[`RTF65004_FLAG_C];
	// shift distance wraps at 64
	assign shamt = exe.imm[5:0] + exe.b[5:0];
	assign byte_x = {{(`RTF65004_WID-9){1'b0}}, byte_r};

	always_comb
	begin
		byte_r = '0;
		case (exe.op)
		`RTF65004_UO_ADDB: byte_r = exe.a[7:0] + exe.imm[7:0] + exe.b[7:0];
		`RTF65004_UO_ADCB: byte_r = exe.a[7:0] + exe.imm[7:0] + exe.b[7:0] + carry;
		`RTF65004_UO_SBCB,
		`RTF65004_UO_CMPB: byte_r = exe.a[7:0] - exe.imm[7:0] - exe.b[7:0] - borrow;
		`RTF65004_UO_ANDB,
		`RTF65004_UO_BITB: byte_r = {1'b0, exe.a[7:0] & exe.imm[7:0] & exe.b[7:0]};
		`RTF65004_UO_ANDC: byte_r = {1'b0, exe.a[7:0] & exe.imm[7:0] & ~exe.b[7:0]};
		`RTF65004_UO_ORB: byte_r = {1'b0, exe.a[7:0] | exe.imm[7:0] | exe.b[7:0]};
		`RTF65004_UO_EORB: byte_r = {1'b0, exe.a[7:0] ^ exe.imm[7:0] ^ exe.b[7:0]};
		`RTF65004_UO_ASLB: byte_r = {exe.a[7:0], 1'b0};
		`RTF65004_UO_LSRB: byte_r = {exe.a[0], 1'b0, exe.a[7:1]};
		`RTF65004_UO_ROLB: byte_r = {exe.a[7:0], carry};
		// carry out of a right rotate is the bit that falls off the bottom
		`RTF65004_UO_RORB: byte_r = {exe.a[0], carry, exe.a[7:1]};
		default: byte_r = '0;
		endcase
	end

	always_comb
	begin
		case (exe.op)
		`RTF65004_UO_LDIB: res = {{(`RTF65004_WID-8){exe.imm[7]}}, exe.imm[7:0]};
		`RTF65004_UO_ADDB, `RTF65004_UO_ADCB, `RTF65004_UO_SBCB, `RTF65004_UO_CMPB,
		`RTF65004_UO_ANDB, `RTF65004_UO_ANDC, `RTF65004_UO_BITB, `RTF65004_UO_ORB,
		`RTF65004_UO_EORB, `RTF65004_UO_ASLB, `RTF65004_UO_LSRB, `RTF65004_UO_ROLB,
		`RTF65004_UO_RORB: res = byte_x;
		`RTF65004_UO_MOV: res = exe.b;
		`RTF65004_UO_ADDW,
		`RTF65004_UO_ADD: res = exe.a + exe.imm + exe.b;
		`RTF65004_UO_SUB,
		`RTF65004_UO_CMP: res = exe.a - exe.imm - exe.b;
		`RTF65004_UO_AND: res = exe.a & exe.imm & exe.b;
		`RTF65004_UO_OR: res = exe.a | exe.imm | exe.b;
		`RTF65004_UO_EOR: res = exe.a ^ exe.imm ^ exe.b;
		`RTF65004_UO_ASL: res = exe.a << shamt;
		`RTF65004_UO_LSR: res = exe.a >> shamt;
		// flag micro-ops write back zero to register 0
		`RTF65004_UO_CLC, `RTF65004_UO_SEC, `RTF65004_UO_CLV, `RTF65004_UO_SEI,
		`RTF65004_UO_CLI, `RTF65004_UO_SED, `RTF65004_UO_CLD, `RTF65004_UO_SEB,
		`RTF65004_UO_CLB, `RTF65004_UO_XCE: res = '0;
		default: res = {(`RTF65004_WID/16){16'hDEAE}};
		endcase
	end

	// byte results flag from the low 8 bits, word logic flags from all bits
	always_comb
	begin
		status_nxt = status_q;
		case (exe.op)
		`RTF65004_UO_LDIB, `RTF65004_UO_ADDB, `RTF65004_UO_ANDB, `RTF65004_UO_BITB,
		`RTF65004_UO_ORB, `RTF65004_UO_EORB, `RTF65004_UO_MOV:
		begin
			status_nxt[`RTF65004_FLAG_Z] = (res[7:0] == 8'h00);
			status_nxt[`RTF65004_FLAG_N] = res[7];
		end
		`RTF65004_UO_ANDC:
			status_nxt[`RTF65004_FLAG_Z] = (res[7:0] == 8'h00);
		`RTF65004_UO_ADCB:
		begin
			status_nxt[`RTF65004_FLAG_C] = res[8];
			status_nxt[`RTF65004_FLAG_Z] = (res[7:0] == 8'h00);
			status_nxt[`RTF65004_FLAG_V] = (res[7] ^ exe.imm[7] ^ exe.b[7])
				& (1'b1 ^ exe.a[7] ^ exe.imm[7] ^ exe.b[7]);
			status_nxt[`RTF65004_FLAG_N] = res[7];
		end
		`RTF65004_UO_SBCB:
		begin
			// carry set means no borrow came out of bit 7
			status_nxt[`RTF65004_FLAG_C] = ~res[8];
			status_nxt[`RTF65004_FLAG_Z] = (res[7:0] == 8'h00);
			status_nxt[`RTF65004_FLAG_V] = (1'b1 ^ res[7] ^ exe.imm[7] ^ exe.b[7])
				& (exe.a[7] ^ exe.imm[7] ^ exe.b[7]);
			status_nxt[`RTF65004_FLAG_N] = res[7];
		end
		`RTF65004_UO_CMPB, `RTF65004_UO_ASLB, `RTF65004_UO_LSRB, `RTF65004_UO_ROLB,
		`RTF65004_UO_RORB:
		begin
			status_nxt[`RTF65004_FLAG_C] = res[8];
			status_nxt[`RTF65004_FLAG_Z] = (res[7:0] == 8'h00);
			status_nxt[`RTF65004_FLAG_N] = res[7];
		end
		`RTF65004_UO_AND, `RTF65004_UO_OR, `RTF65004_UO_EOR:
		begin
			status_nxt[`RTF65004_FLAG_Z] = (res == '0);
			status_nxt[`RTF65004_FLAG_N] = res[`RTF65004_WID-1];
		end
		// word arithmetic and shifts leave the flags as they are
		`RTF65004_UO_ADDW, `RTF65004_UO_ADD, `RTF65004_UO_SUB, `RTF65004_UO_CMP,
		`RTF65004_UO_ASL, `RTF65004_UO_LSR: status_nxt = status_q;
		`RTF65004_UO_CLC: status_nxt[`RTF65004_FLAG_C] = 1'b0;
		`RTF65004_UO_SEC: status_nxt[`RTF65004_FLAG_C] = 1'b1;
		`RTF65004_UO_CLV: status_nxt[`RTF65004_FLAG_V] = 1'b0;
		`RTF65004_UO_SEI: status_nxt[`RTF65004_FLAG_I] = 1'b1;
		`RTF65004_UO_CLI: status_nxt[`RTF65004_FLAG_I] = 1'b0;
		`RTF65004_UO_SED: status_nxt[`RTF65004_FLAG_D] = 1'b1;
		`RTF65004_UO_CLD: status_nxt[`RTF65004_FLAG_D] = 1'b0;
		`RTF65004_UO_SEB: status_nxt[`RTF65004_FLAG_B] = 1'b1;
		`RTF65004_UO_CLB: status_nxt[`RTF65004_FLAG_B] = 1'b0;
		// swap the native and the alternate status byte
		`RTF65004_UO_XCE: status_nxt = {status_q[7:0], status_q[15:8]};
		default: status_nxt = '0;
		endcase
	end

	// ========================================================================
	// status register and writeback holder
	// ========================================================================

	// a new micro-op is taken when the holder is empty or drains on this edge
	assign exe.ready = (state_q == rtf65004_pkg::wb_idle) || wb_ready_i;
	assign take = exe.valid && exe.ready;

	always_ff @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			status_q <= '0;
			state_q <= rtf65004_pkg::wb_idle;
		end
		else
		begin
			if (take)
			begin
				status_q <= status_nxt;
				state_q <= rtf65004_pkg::wb_full;
			end
			else if (wb_valid_o && wb_ready_i)
				state_q <= rtf65004_pkg::wb_idle;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (take)
		begin
			wb_dst_q <= exe.dst;
			wb_data_q <= res;
		end
	end

	assign wb_valid_o = (state_q == rtf65004_pkg::wb_full);
	assign wb_dst_o = wb_dst_q;
	assign wb_data_o = wb_data_q;
	assign status_o = status_q;

endmodule

/* src/rtf65004_exec.sv */
// top level of the execution slice joining register read, issue queue and ALU stage
module rtf65004_exec
(
	input  logic clk_i,
	input  logic rst_n_i,
	// micro-op input channel
	input  logic uop_valid_i,
	output logic uop_ready_o,
	input  rtf65004_pkg::uop_code_t uop_op_i,
	input  rtf65004_pkg::reg_idx_t uop_dst_i,
	input  rtf65004_pkg::reg_idx_t uop_src_a_i,
	input  rtf65004_pkg::reg_idx_t uop_src_b_i,
	input  rtf65004_pkg::word_t uop_imm_i,
	// writeback output channel
	output logic wb_valid_o,
	input  logic wb_ready_i,
	output rtf65004_pkg::reg_idx_t wb_dst_o,
	output rtf65004_pkg::word_t wb_data_o,
	output rtf65004_pkg::status_t status_o
);

	// register read to queue, and queue to ALU
	rtf65004_uop_if u_issue_if ();
	rtf65004_uop_if u_exe_if ();

	// the register file records a result on the same edge it leaves the slice
	logic wb_we;

	assign wb_we = wb_valid_o && wb_ready_i;

	rtf65004_regread i_regread
	(
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.uop_valid_i(uop_valid_i),
		.uop_ready_o(uop_ready_o),
		.uop_op_i   (uop_op_i),
		.uop_dst_i  (uop_dst_i),
		.uop_src_a_i(uop_src_a_i),
		.uop_src_b_i(uop_src_b_i),
		.uop_imm_i  (uop_imm_i),
		.wb_we_i    (wb_we),
		.wb_dst_i   (wb_dst_o),
		.wb_data_i  (wb_data_o),
		.issue      (u_issue_if.src)
	);

	rtf65004_uop_fifo i_uop_fifo
	(
		.clk_i  (clk_i),
		.rst_n_i(rst_n_i),
		.wr     (u_issue_if.snk),
		.rd     (u_exe_if.src)
	);

	rtf65004_alu_stage i_alu_stage
	(
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.exe       (u_exe_if.snk),
		.wb_valid_o(wb_valid_o),
		.wb_ready_i(wb_ready_i),
		.wb_dst_o  (wb_dst_o),
		.wb_data_o (wb_data_o),
		.status_o  (status_o)
	);

endmodule

/* testbench/tb_rtf65004_exec.sv */
// testbench for the execution slice with random micro-ops, a reference model, checks and a timeout
`include "rtf65004_defines.svh"

module tb_rtf65004_exec;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_UOPS = 400;
	localparam int RESET_CYCLES = 10;
	// every micro-op gets a generous slice for gaps, hazard stalls and back-pressure
	localparam int TIMEOUT_CYCLES = MAX_UOPS * 24 + RESET_CYCLES;

	// one micro-op as offered on the input channel
	typedef struct packed
	{
		rtf65004_pkg::uop_code_t op;
		rtf65004_pkg::reg_idx_t dst;
		rtf65004_pkg::reg_idx_t a;
		rtf65004_pkg::reg_idx_t b;
		rtf65004_pkg::word_t imm;
	} uop_t;

	// what the model expects to see at a writeback handshake
	typedef struct packed
	{
		rtf65004_pkg::reg_idx_t dst;
		rtf65004_pkg::word_t data;
		rtf65004_pkg::status_t status;
	} wb_exp_t;

	logic clk_i = 1'b0;
	logic rst_n_i;
	logic uop_valid_i;
	logic uop_ready_o;
	rtf65004_pkg::uop_code_t uop_op_i;
	rtf65004_pkg::reg_idx_t uop_dst_i;
	rtf65004_pkg::reg_idx_t uop_src_a_i;
	rtf65004_pkg::reg_idx_t uop_src_b_i;
	rtf65004_pkg::word_t uop_imm_i;
	logic wb_valid_o;
	logic wb_ready_i;
	rtf65004_pkg::reg_idx_t wb_dst_o;
	rtf65004_pkg::word_t wb_data_o;
	rtf65004_pkg::status_t status_o;

	logic [31:0] seed = 32'h6ff2;
	uop_t stim_q [$];
	wb_exp_t exp_q [$];
	wb_exp_t head;
	// the reference model keeps the architectural state and never writes register 0
	rtf65004_pkg::word_t m_regs [8];
	rtf65004_pkg::status_t m_status;
	// stream position, idle gap and the index ranges of the dependent and back-pressure phases
	int stim_idx = 0;
	int gap_cnt = 0;
	int dep_from = 0;
	int dep_to = 0;
	int bp_from = 0;
	int bp_left = 0;
	logic acc_last = 1'b0;
	logic running = 1'b0;
	int errors = 0;
	int checks = 0;
	int acc_count = 0;
	int wb_count = 0;
	int cycles = 0;

	rtf65004_exec i_rtf65004_exec
	(
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.uop_valid_i(uop_valid_i),
		.uop_ready_o(uop_ready_o),
		.uop_op_i   (uop_op_i),
		.uop_dst_i  (uop_dst_i),
		.uop_src_a_i(uop_src_a_i),
		.uop_src_b_i(uop_src_b_i),
		.uop_imm_i  (uop_imm_i),
		.wb_valid_o (wb_valid_o),
		.wb_ready_i (wb_ready_i),
		.wb_dst_o   (wb_dst_o),
		.wb_data_o  (wb_data_o),
		.status_o   (status_o)
	);

	always
	begin
		#10 clk_i = ~clk_i;
	end

	// ========================================================================
	// random numbers and stimulus helpers
	// ========================================================================

	// linear congruential generator whose output folds the high half into the weak low bits
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed ^ (seed >> 16);
	endfunction

	// mostly full width values and now and then a small byte so carries show up
	function automatic rtf65004_pkg::word_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		if (hi[3:0] == 4'h0)
			return 64'(lo[7:0]);
		return {hi, lo};
	endfunction

	// three quarters of the time a micro-op is followed by no idle cycle at all
	function automatic int pick_gap();
		logic [31:0] r;
		r = next_rand();
		if (r[4:3] != 2'b00)
			return 0;
		return 1 + int'(r[9:8]);
	endfunction

	task automatic add_uop(input rtf65004_pkg::uop_code_t op, input rtf65004_pkg::reg_idx_t dst,
		input rtf65004_pkg::reg_idx_t a, input rtf65004_pkg::reg_idx_t b,
		input rtf65004_pkg::word_t imm);
		uop_t u;
		u.op = op;
		u.dst = dst;
		u.a = a;
		u.b = b;
		u.imm = imm;
		stim_q.push_back(u);
	endtask

	task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ========================================================================
	// reference model
	// ========================================================================

	// executes one micro-op in acceptance order and queues the expected writeback
	task automatic model_exec(input uop_t u);
		rtf65004_pkg::word_t a;
		rtf65004_pkg::word_t b;
		rtf65004_pkg::word_t imm;
		rtf65004_pkg::word_t res;
		rtf65004_pkg::status_t st;
		wb_exp_t e;
		logic [8:0] r9;
		logic [5:0] sh;
		logic c;
		logic s2;
		logic byte9;
		logic zn8;
		logic z_only;
		a = m_regs[u.a];
		b = m_regs[u.b];
		imm = u.imm;
		st = m_status;
		c = st[`RTF65004_FLAG_C];
		// the immediate and the second register act as one combined operand with this sign
		s2 = imm[7] ^ b[7];
		sh = imm[5:0] + b[5:0];
		res = '0;
		r9 = '0;
		byte9 = 1'b0;
		zn8 = 1'b0;
		z_only = 1'b0;
		case (u.op)
		`RTF65004_UO_LDIB:
		begin
			res = {{56{imm[7]}}, imm[7:0]};
			zn8 = 1'b1;
		end
		`RTF65004_UO_ADDW, `RTF65004_UO_ADD: res = a + imm + b;
		`RTF65004_UO_ADDB:
		begin
			r9 = 9'(a[7:0]) + 9'(imm[7:0]) + 9'(b[7:0]);
			byte9 = 1'b1;
			zn8 = 1'b1;
		end
		`RTF65004_UO_ADCB:
		begin
			r9 = 9'(a[7:0]) + 9'(imm[7:0]) + 9'(b[7:0]) + {8'h00, c};
			st[`RTF65004_FLAG_C] = r9[8];
			// signed overflow when both inputs share a sign that the sum lost
			st[`RTF65004_FLAG_V] = (a[7] == s2) && (r9[7] != a[7]);
			byte9 = 1'b1;
			zn8 = 1'b1;
		end
		`RTF65004_UO_SBCB, `RTF65004_UO_CMPB:
		begin
			r9 = 9'(a[7:0]) - 9'(imm[7:0]) - 9'(b[7:0]) - {8'h00, !c};
			// SBCB reports carry as no borrow while CMPB passes bit 8 straight through
			if (u.op == `RTF65004_UO_SBCB)
			begin
				st[`RTF65004_FLAG_C] = !r9[8];
				st[`RTF65004_FLAG_V] = (a[7] != s2) && (r9[7] != a[7]);
			end
			else
				st[`RTF65004_FLAG_C] = r9[8];
			byte9 = 1'b1;
			zn8 = 1'b1;
		end
		`RTF65004_UO_ANDB, `RTF65004_UO_BITB:
		begin
			r9 = {1'b0, a[7:0] & imm[7:0] & b[7:0]};
			byte9 = 1'b1;
			zn8 = 1'b1;
		end
		`RTF65004_UO_ANDC:
		begin
			r9 = {1'b0, a[7:0] & imm[7:0] & ~b[7:0]};
			byte9 = 1'b1;
			z_only = 1'b1;
		end
		`RTF65004_UO_ORB, `RTF65004_UO_EORB:
		begin
			if (u.op == `RTF65004_UO_ORB)
				r9 = {1'b0, a[7:0] | imm[7:0] | b[7:0]};
			else
				r9 = {1'b0, a[7:0] ^ imm[7:0] ^ b[7:0]};
			byte9 = 1'b1;
			zn8 = 1'b1;
		end
		`RTF65004_UO_MOV:
		begin
			res = b;
			zn8 = 1'b1;
		end
		// byte shifts and rotates leave the bit shifted out in bit 8, which becomes C
		`RTF65004_UO_ASLB, `RTF65004_UO_LSRB, `RTF65004_UO_ROLB, `RTF65004_UO_RORB:
		begin
			if (u.op == `RTF65004_UO_ASLB)
				r9 = {a[7:0], 1'b0};
			else if (u.op == `RTF65004_UO_LSRB)
				r9 = {a[0], 1'b0, a[7:1]};
			else if (u.op == `RTF65004_UO_ROLB)
				r9 = {a[7:0], c};
			else
				r9 = {a[0], c, a[7:1]};
			st[`RTF65004_FLAG_C] = r9[8];
			byte9 = 1'b1;
			zn8 = 1'b1;
		end
		`RTF65004_UO_SUB, `RTF65004_UO_CMP: res = a - imm - b;
		`RTF65004_UO_AND, `RTF65004_UO_OR, `RTF65004_UO_EOR:
		begin
			if (u.op == `RTF65004_UO_AND)
				res = a & imm & b;
			else if (u.op == `RTF65004_UO_OR)
				res = a | imm | b;
			else
				res = a ^ imm ^ b;
			st[`RTF65004_FLAG_Z] = (res == '0);
			st[`RTF65004_FLAG_N] = res[63];
		end
		`RTF65004_UO_ASL: res = a << sh;
		`RTF65004_UO_LSR: res = a >> sh;
		`RTF65004_UO_CLC: st[`RTF65004_FLAG_C] = 1'b0;
		`RTF65004_UO_SEC: st[`RTF65004_FLAG_C] = 1'b1;
		`RTF65004_UO_CLV: st[`RTF65004_FLAG_V] = 1'b0;
		`RTF65004_UO_SEI: st[`RTF65004_FLAG_I] = 1'b1;
		`RTF65004_UO_CLI: st[`RTF65004_FLAG_I] = 1'b0;
		`RTF65004_UO_SED: st[`RTF65004_FLAG_D] = 1'b1;
		`RTF65004_UO_CLD: st[`RTF65004_FLAG_D] = 1'b0;
		`RTF65004_UO_SEB: st[`RTF65004_FLAG_B] = 1'b1;
		`RTF65004_UO_CLB: st[`RTF65004_FLAG_B] = 1'b0;
		`RTF65004_UO_XCE: st = {st[7:0], st[15:8]};
		default:
		begin
			res = {4{16'hDEAE}};
			st = '0;
		end
		endcase
		if (byte9)
			res = 64'(r9);
		if (zn8 || z_only)
			st[`RTF65004_FLAG_Z] = (res[7:0] == 8'h00);
		if (zn8)
			st[`RTF65004_FLAG_N] = res[7];
		m_status = st;
		if (u.dst != '0)
			m_regs[u.dst] = res;
		e.dst = u.dst;
		e.data = res;
		e.status = st;
		exp_q.push_back(e);
	endtask

	// ========================================================================
	// stimulus program
	// ========================================================================

	task automatic build_stimulus();
		rtf65004_pkg::reg_idx_t prev;
		rtf65004_pkg::reg_idx_t dst;
		// load every register with a byte and read each one back through MOV
		for (int r = 1; r < 8; r++)
			add_uop(`RTF65004_UO_LDIB, 3'(r), 3'd0, 3'd0, rand_word());
		for (int r = 1; r < 8; r++)
			add_uop(`RTF65004_UO_MOV, 3'd0, 3'd0, 3'(r), 64'd0);
		// explicit add and subtract carry chains
		add_uop(`RTF65004_UO_CLC, 3'd0, 3'd0, 3'd0, 64'd0);
		for (int r = 1; r < 5; r++)
			add_uop(`RTF65004_UO_ADCB, 3'(r), 3'(r), 3'(r + 1), 64'hff);
		add_uop(`RTF65004_UO_SEC, 3'd0, 3'd0, 3'd0, 64'd0);
		for (int r = 1; r < 5; r++)
			add_uop(`RTF65004_UO_SBCB, 3'(r), 3'(r), 3'(r + 2), 64'h01);
		// random byte and word arithmetic, logic and shifts
		for (int i = 0; i < 170; i++)
			add_uop(6'(next_rand() % 24), 3'(next_rand()), 3'(next_rand()), 3'(next_rand()),
				rand_word());
		// flag micro-ops to register 0 and then register 0 must still read zero
		for (int i = 0; i < 40; i++)
			add_uop(6'(`RTF65004_UO_CLC + next_rand() % 10), 3'd0, 3'(next_rand()),
				3'(next_rand()), rand_word());
		add_uop(`RTF65004_UO_LDIB, 3'd0, 3'd0, 3'd0, 64'h7f);
		add_uop(`RTF65004_UO_MOV, 3'd0, 3'd0, 3'd0, 64'd0);
		add_uop(`RTF65004_UO_MOV, 3'd1, 3'd0, 3'd0, 64'd0);
		// each micro-op reads the register that the previous one writes
		dep_from = stim_q.size();
		prev = 3'd1;
		for (int i = 0; i < 40; i++)
		begin
			dst = 3'(1 + next_rand() % 7);
			add_uop(6'(next_rand() % 24), dst, prev, 3'(next_rand()), rand_word());
			prev = dst;
		end
		dep_to = stim_q.size();
		// every code including unknown ones while the writeback side stalls
		bp_from = stim_q.size();
		for (int i = 0; i < 100; i++)
			add_uop(6'(next_rand() % 40), 3'(next_rand()), 3'(next_rand()), 3'(next_rand()),
				rand_word());
	endtask

	task automatic drive_uop(input uop_t u);
		uop_valid_i = 1'b1;
		uop_op_i = u.op;
		uop_dst_i = u.dst;
		uop_src_a_i = u.a;
		uop_src_b_i = u.b;
		uop_imm_i = u.imm;
	endtask

	// ========================================================================
	// driver, monitor and timeout
	// ========================================================================

	// inputs change shortly after the rising edge and handshakes are judged at the falling edge
	always @(posedge clk_i)
	begin
		#2;
		if (running)
		begin
			if (uop_valid_i && acc_last)
				uop_valid_i = 1'b0;
			if (!uop_valid_i)
			begin
				if (gap_cnt > 0)
					gap_cnt--;
				else if (stim_idx < stim_q.size())
				begin
					drive_uop(stim_q[stim_idx]);
					stim_idx++;
					// the dependent phase runs back to back so every source stalls
					if (stim_idx < dep_from || stim_idx >= dep_to)
						gap_cnt = pick_gap();
				end
			end
			if (stim_idx > bp_from)
			begin
				if (bp_left == 0)
				begin
					wb_ready_i = ~wb_ready_i;
					bp_left = 1 + int'(next_rand() % 8);
				end
				else
					bp_left--;
			end
			else
				wb_ready_i = 1'b1;
		end
	end

	always @(negedge clk_i)
	begin
		if (rst_n_i === 1'b1)
		begin
			acc_last = uop_valid_i && uop_ready_o;
			if (wb_valid_o && wb_ready_i)
			begin
				wb_count++;
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("ERROR at %0t ns: a writeback came with no micro-op outstanding",
						$time);
				end
				else
				begin
					head = exp_q.pop_front();
					check_val("wb_dst_o", 64'(wb_dst_o), 64'(head.dst));
					check_val("wb_data_o", wb_data_o, head.data);
					check_val("status_o", 64'(status_o), 64'(head.status));
				end
			end
			if (acc_last)
			begin
				acc_count++;
				model_exec({uop_op_i, uop_dst_i, uop_src_a_i, uop_src_b_i, uop_imm_i});
			end
		end
	end

	always @(posedge clk_i)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("ERROR: timeout after %0d cycles, the micro-op stream never drained", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial
	begin
		rst_n_i = 1'b0;
		uop_valid_i = 1'b0;
		uop_op_i = '0;
		uop_dst_i = '0;
		uop_src_a_i = '0;
		uop_src_b_i = '0;
		uop_imm_i = '0;
		wb_ready_i = 1'b1;
		for (int r = 0; r < 8; r++)
			m_regs[r] = '0;
		m_status = '0;
		build_stimulus();
		repeat (RESET_CYCLES) @(posedge clk_i);
		#2;
		rst_n_i = 1'b1;
		@(negedge clk_i);
		check_val("wb_valid_o after reset", 64'(wb_valid_o), 64'd0);
		check_val("status_o after reset", 64'(status_o), 64'd0);
		running = 1'b1;
		while (stim_idx < stim_q.size() || uop_valid_i || exp_q.size() != 0)
			@(posedge clk_i);
		// a few quiet cycles expose any extra writeback
		repeat (8) @(posedge clk_i);
		@(negedge clk_i);
		check_val("writebacks", 64'(wb_count), 64'(stim_q.size()));
		check_val("wb_valid_o when drained", 64'(wb_valid_o), 64'd0);
		check_val("uop_ready_o when drained", 64'(uop_ready_o), 64'd1);
		$display("checks: %0d, errors: %0d, micro-ops: %0d, writebacks: %0d",
			checks, errors, acc_count, wb_count);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* project.f */
+incdir+src
src/rtf65004_pkg.sv
src/rtf65004_uop_if.sv
src/rtf65004_regread.sv
src/rtf65004_uop_fifo.sv
src/rtf65004_alu_stage.sv
src/rtf65004_exec.sv
testbench/tb_rtf65004_exec.sv

/* Makefile */
# Verilator build and run of the execution slice testbench

VERILATOR ?= verilator
TOP       ?= tb_rtf65004_exec
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
